/* dv/tb_gem_tx_ref.svh */
`ifndef TB_GEM_TX_REF_SVH
`define TB_GEM_TX_REF_SVH

// ------------------------------
// Expected link frames
// ------------------------------

// Word 0 of a frame sits at index 0
typedef tx_link_s [FRAME_LEN-1:0] link_frame_t;

// Separator for one cluster word
function automatic k_char_t expected_sep(input gem_word_s w);
   k_char_t cycle_code [4];                       // Indexed by bunch-crossing LSBs
   cycle_code = '{K_SEP0, K_SEP1, K_SEP2, K_SEP3};
   if (w.bc0) begin
      return K_BC0;                               // BC0 beats every other code
   end
   if (w.resync) begin
      return K_RESYNC;
   end
   if (w.overflow) begin
      return K_OVERFLOW;
   end
   return cycle_code[w.bxn_lsbs];
endfunction

// Four link words that carry one cluster word
function automatic link_frame_t expected_frame(input gem_word_s w);
   link_frame_t frame;
   frame[0].data = {w.data[7:0], expected_sep(w)}; // Separator in the low byte
   frame[0].isk  = ISK_SEP;
   for (int i = 1; i < FRAME_LEN; i++) begin
      frame[i].data = w.data[16*i-8 +: 16];       // 23..8, 39..24, 55..40
      frame[i].isk  = ISK_DATA;
   end
   return frame;
endfunction

`endif

/* dv/tb_gem_tx.sv */
`timescale 1ns/1ps

module tb_gem_tx import tx_frame_pkg::*, link_ctrl_pkg::*;;

   `include "tb_gem_tx_ref.svh"

   localparam int NUM_RANDOM_WORDS = 300;
   localparam int FORCE_CYCLES     = 10;      // Length of the not-ready pulse
   localparam int DRAIN_CYCLES     = 4 * TX_BUF_DEPTH * FRAME_LEN;  // Full buffer leaving
   localparam int TIMEOUT_CYCLES   = 2 * (STARTUP_HOLD_CYCLES + LINK_RESET_CYCLES
                                     + int'(READY_CNT_MAX) + 20 * NUM_RANDOM_WORDS * FRAME_LEN);

   logic      clock_40;
   logic      rst_n_i;
   logic      word_valid_i;
   gem_word_s word_i;
   logic      force_not_ready_i;
   logic      credit_o;
   tx_link_s  tx_o;
   logic      link_up_o;
   logic      ready_o;

   gem_word_s exp_q [$];                      // Words sent, oldest first
   int words_sent     = 0;
   int credit_returns = 0;
   int error_count    = 0;
   int frames_checked = 0;
   int idle_frames    = 0;
   int link_rises     = 0;
   int ready_rises    = 0;

   gem_tx_top dut0 (
      .clock_40          (clock_40),
      .rst_n_i           (rst_n_i),
      .word_valid_i      (word_valid_i),
      .word_i            (word_i),
      .force_not_ready_i (force_not_ready_i),
      .credit_o          (credit_o),
      .tx_o              (tx_o),
      .link_up_o         (link_up_o),
      .ready_o           (ready_o)
   );

   always #10 clock_40 = ~clock_40;           // 20 ns period

   // ------------------------------
   // Helpers
   // ------------------------------

   task automatic flag_mismatch(input string msg);
      error_count++;
      $display("[FAIL] t=%0t %s", $time, msg);
   endtask

   task automatic finish_run();
      $display("Frames checked %0d, idle frames %0d, words sent %0d, credits %0d, errors %0d",
               frames_checked, idle_frames, words_sent, credit_returns, error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   endtask

   // Spend one credit, stall while none is left
   task automatic send_word(input gem_word_s w);
      @(posedge clock_40);
      while (words_sent - credit_returns >= TX_BUF_DEPTH) begin
         word_valid_i <= 1'b0;
         @(posedge clock_40);
      end
      word_valid_i <= 1'b1;
      word_i       <= w;
      words_sent   <= words_sent + 1;
      exp_q.push_back(w);
   endtask

   task automatic pause(input int n);
      repeat (n) begin
         @(posedge clock_40);
         word_valid_i <= 1'b0;
      end
   endtask

   // Non-zero payload, flags set in about a third of the words
   function automatic gem_word_s random_word();
      gem_word_s w;
      w.data = cluster_data_t'({$urandom(), $urandom()});
      if (w.data == '0) begin
         w.data = cluster_data_t'(1);
      end
      w.bxn_lsbs = bxn_lsb_t'($urandom_range(0, 3));
      {w.bc0, w.resync, w.overflow} = 3'b000;
      if ($urandom_range(0, 9) < 3) begin
         {w.bc0, w.resync, w.overflow} = 3'($urandom_range(1, 7));
      end
      return w;
   endfunction

   function automatic gem_word_s directed_word(input logic [2:0] flags, input bxn_lsb_t bxn);
      gem_word_s w;
      w.data     = cluster_data_t'({$urandom(), $urandom()}) | cluster_data_t'(1);
      {w.bc0, w.resync, w.overflow} = flags;
      w.bxn_lsbs = bxn;
      return w;
   endfunction

   // ------------------------------
   // Credit counter
   // ------------------------------

   always @(posedge clock_40) begin : credit_counter
      if (credit_o) begin
         if (credit_returns >= words_sent) begin
            flag_mismatch($sformatf("credit %0d returned with only %0d words sent",
                                    credit_returns + 1, words_sent));
         end
         credit_returns <= credit_returns + 1;
      end
   end

   // ------------------------------
   // Link and ready monitor
   // ------------------------------

   always @(posedge clock_40) begin : link_monitor
      int   edge_cnt;
      int   link_low_cnt;                     // Cycles out of reset with the link down
      int   ready_wait;                       // Clean link cycles before ready
      logic link_up_prev;
      logic ready_prev;
      logic force_prev;
      if (edge_cnt >= 2) begin
         if (!link_up_o) begin
            if (tx_o !== IDLE_LINK_WORD) flag_mismatch($sformatf("tx_o %h not idle", tx_o));
            if (credit_o !== 1'b0) flag_mismatch("credit_o high while link is down");
            if (ready_o !== 1'b0) flag_mismatch("ready_o high while link is down");
            if (rst_n_i) link_low_cnt++;
         end
         if (link_up_o && !link_up_prev) begin
            link_rises++;
            if (link_low_cnt != STARTUP_HOLD_CYCLES + LINK_RESET_CYCLES) begin
               flag_mismatch($sformatf("link_up_o rose after %0d cycles", link_low_cnt));
            end
         end
         if (!link_up_o && link_up_prev) flag_mismatch("link_up_o dropped");
         if (force_not_ready_i) begin
            ready_wait = 0;                   // Timer held clear
         end else if (link_up_o && !ready_o) begin
            ready_wait++;
         end
         if (ready_o && !ready_prev) begin
            ready_rises++;
            if (ready_wait != int'(READY_CNT_MAX)) begin
               flag_mismatch($sformatf("ready_o rose after %0d cycles", ready_wait));
            end
         end
         if (force_prev && ready_o) flag_mismatch("ready_o still high under force_not_ready_i");
      end
      edge_cnt++;
      link_up_prev = link_up_o;
      ready_prev   = ready_o;
      force_prev   = force_not_ready_i;
   end

   // ------------------------------
   // Frame checker
   // ------------------------------

   always @(posedge clock_40) begin : frame_checker
      int          word_idx;                  // Next slot of the frame being collected
      logic        link_up_seen;              // First word follows one cycle after link_up
      logic        idle;
      link_frame_t got;
      link_frame_t exp_frame;
      if (link_up_o && link_up_seen) begin
         if (word_idx == 0 && tx_o.isk != ISK_SEP) begin
            flag_mismatch($sformatf("expected frame start, got isk %b", tx_o.isk));
         end else begin
            if (word_idx != 0 && tx_o.isk != ISK_DATA) begin
               flag_mismatch($sformatf("word %0d has isk %b", word_idx, tx_o.isk));
            end
            got[word_idx] = tx_o;
            if (word_idx == FRAME_LEN - 1) begin
               word_idx = 0;
               idle = (got[0].data == {8'h00, K_SEP0});
               for (int i = 1; i < FRAME_LEN; i++) begin
                  if (got[i].data != '0) idle = 1'b0;
               end
               if (idle) begin
                  idle_frames++;
               end else if (exp_q.size() == 0) begin
                  flag_mismatch($sformatf("frame %h with no word sent", got));
               end else begin
                  exp_frame = expected_frame(exp_q.pop_front());
                  frames_checked++;
                  if (got != exp_frame) begin
                     flag_mismatch($sformatf("frame %0d got %h expected %h",
                                             frames_checked, got, exp_frame));
                  end
               end
            end else begin
               word_idx++;
            end
         end
      end
      link_up_seen = link_up_o;
   end

   // ------------------------------
   // Stimulus
   // ------------------------------

   initial begin : stimulus
      int drain_wait;                         // Cycles spent waiting for the last frames
      clock_40          = 1'b0;
      rst_n_i           = 1'b0;
      word_valid_i      = 1'b0;
      word_i            = '0;
      force_not_ready_i = 1'b0;
      void'($urandom(12));
      repeat (8) @(posedge clock_40);
      rst_n_i <= 1'b1;

      // First four fill the buffer before the link is up, the rest wait for credits
      send_word(directed_word(3'b111, 2'd1));   // 1C
      send_word(directed_word(3'b011, 2'd2));   // 3C
      send_word(directed_word(3'b001, 2'd3));   // FE
      send_word(directed_word(3'b100, 2'd0));
      send_word(directed_word(3'b010, 2'd0));
      for (int b = 0; b < 4; b++) begin
         send_word(directed_word(3'b000, bxn_lsb_t'(b)));  // BC F7 FB FD
      end
      pause(1);
      while (!ready_o) @(posedge clock_40);

      for (int n = 0; n < NUM_RANDOM_WORDS; n++) begin
         send_word(random_word());
         if ($urandom_range(0, 3) == 0) pause($urandom_range(1, 6));
      end
      pause(1);

      // Drop and recover ready
      force_not_ready_i <= 1'b1;
      repeat (FORCE_CYCLES) @(posedge clock_40);
      force_not_ready_i <= 1'b0;
      @(posedge clock_40);
      while (!ready_o) @(posedge clock_40);

      // Bounded drain so a lost word shows up in the checks below
      drain_wait = 0;
      while (exp_q.size() != 0 && drain_wait < DRAIN_CYCLES) begin
         @(posedge clock_40);
         drain_wait++;
      end
      repeat (2 * FRAME_LEN) @(posedge clock_40);
      if (credit_returns != words_sent) begin
         flag_mismatch($sformatf("%0d credits for %0d words", credit_returns, words_sent));
      end
      if (exp_q.size() != 0) flag_mismatch($sformatf("%0d words never framed", exp_q.size()));
      if (link_rises != 1) flag_mismatch($sformatf("link_up_o rose %0d times", link_rises));
      if (ready_rises != 2) flag_mismatch($sformatf("ready_o rose %0d times", ready_rises));
      finish_run();
   end

   // Run limit
   initial begin : watchdog
      for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
         @(posedge clock_40);
      end
      $display("Timeout: the test did not complete within %0d cycles", TIMEOUT_CYCLES);
      error_count++;
      finish_run();
   end

endmodule

/* flist.f */
+incdir+dv
source/tx_frame_pkg.sv
source/link_ctrl_pkg.sv
source/link_ctrl.sv
source/tx_word_buffer.sv
source/tx_framer.sv
source/gem_tx_top.sv
dv/tb_gem_tx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the GEM TX link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_gem_tx -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator compile failed with status $status"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_gem_tx)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation finished: PASS"; then
   exit 0
fi
exit 1

/* source/gem_tx_top.sv */
`timescale 1ns/1ps

module gem_tx_top import tx_frame_pkg::*, link_ctrl_pkg::*; (
   input  logic      clock_40,
   input  logic      rst_n_i,
   input  logic      word_valid_i,       // Costs the sender one credit
   input  gem_word_s word_i,
   input  logic      force_not_ready_i,
   output logic      credit_o,           // One credit returned per pulse
   output tx_link_s  tx_o,               // Lane 0 link word
   output logic      link_up_o,
   output logic      ready_o
);

   gem_word_s buf_head;                  // Buffer head seen by the framer
   logic      buf_not_empty;
   logic      framer_pop;

   // ------------------------------
   // Link control
   // ------------------------------

   link_ctrl u_link_ctrl (
      .clock_40          (clock_40),
      .rst_n_i           (rst_n_i),
      .force_not_ready_i (force_not_ready_i),
      .link_up_o         (link_up_o),
      .ready_o           (ready_o)
   );

   // ------------------------------
   // Buffer and framer
   // ------------------------------

   tx_word_buffer u_tx_word_buffer (
      .clock_40     (clock_40),
      .rst_n_i      (rst_n_i),
      .word_valid_i (word_valid_i),
      .word_i       (word_i),
      .pop_i        (framer_pop),
      .head_o       (buf_head),
      .not_empty_o  (buf_not_empty),
      .credit_o     (credit_o)
   );

   tx_framer u_tx_framer (
      .clock_40    (clock_40),
      .rst_n_i     (rst_n_i),
      .link_up_i   (link_up_o),          // Steered by link control
      .head_i      (buf_head),
      .not_empty_i (buf_not_empty),
      .pop_o       (framer_pop),
      .tx_o        (tx_o)
   );

endmodule

/* source/link_ctrl.sv */
`timescale 1ns/1ps

module link_ctrl import link_ctrl_pkg::*; (
   input  logic clock_40,
   input  logic rst_n_i,
   input  logic force_not_ready_i,    // Clears the ready timer while high
   output logic link_up_o,            // Framer may send data
   output logic ready_o               // Link stable for READY_CNT_MAX cycles
);

   startup_state_e state;
   startup_cnt_t   step_cnt;          // Shared by both timed phases
   ready_cnt_t     ready_cnt;

   // ------------------------------
   // Startup sequencer
   // ------------------------------

   // Stands in for the transceiver reset sequence
   always_ff @(posedge clock_40 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state    <= STARTUP_HOLD;
         step_cnt <= '0;
      end else begin
         case (state)
            STARTUP_HOLD: begin
               if (step_cnt == startup_cnt_t'(STARTUP_HOLD_CYCLES - 1)) begin
                  state    <= LINK_RESET;
                  step_cnt <= '0;      // Restart for the reset phase
               end else begin
                  step_cnt <= step_cnt + 1'b1;
               end
            end
            LINK_RESET: begin
               if (step_cnt == startup_cnt_t'(LINK_RESET_CYCLES - 1)) begin
                  state    <= LINK_UP;
                  step_cnt <= '0;
               end else begin
                  step_cnt <= step_cnt + 1'b1;
               end
            end
            LINK_UP: begin
               step_cnt <= '0;         // Parked until the next reset
            end
            default: begin
               state    <= STARTUP_HOLD;
               step_cnt <= '0;
            end
         endcase
      end
   end

   assign link_up_o = (state == LINK_UP);

   // ------------------------------
   // Ready timer
   // ------------------------------

   // Saturating count of clean link cycles
   always_ff @(posedge clock_40 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ready_cnt <= '0;
      end else if (!link_up_o || force_not_ready_i) begin
         ready_cnt <= '0;              // Start over
      end else if (ready_cnt != READY_CNT_MAX) begin
         ready_cnt <= ready_cnt + 1'b1;
      end
   end

   assign ready_o = (ready_cnt == READY_CNT_MAX); // Stays high at saturation

   // Ready must never be reported on a link that is not up
   a_ready_needs_link : assert property (
      @(posedge clock_40) disable iff (!rst_n_i)
      ready_o |-> link_up_o
   ) else $error("ready_o high while link_up_o is low");

endmodule

/* source/link_ctrl_pkg.sv */
package link_ctrl_pkg;

   // ------------------------------
   // Startup sequence
   // ------------------------------

   // Scaled far down from the hardware values so simulation stays short
   localparam int STARTUP_HOLD_CYCLES = 64;   // Link held in reset
   localparam int LINK_RESET_CYCLES   = 32;   // Transceiver reset pulse

   // Shared step count, must hold the longer of the two phases
   typedef logic [$clog2(STARTUP_HOLD_CYCLES)-1:0] startup_cnt_t;

   typedef enum logic [1:0] {
      STARTUP_HOLD,                           // Waiting after reset release
      LINK_RESET,                             // Transceiver TX reset
      LINK_UP                                 // Framer may send
   } startup_state_e;

   // ------------------------------
   // Ready timer
   // ------------------------------

   typedef logic [7:0] ready_cnt_t;

   // Cycles of clean link_up before ready is reported
   localparam ready_cnt_t READY_CNT_MAX = 8'd255;

endpackage

/* source/tx_frame_pkg.sv */
package tx_frame_pkg;

   // ------------------------------
   // Widths with a meaning
   // ------------------------------

   typedef logic [55:0] cluster_data_t;    // Eight GEM clusters, 7 bits each
   typedef logic [15:0] link_word_t;       // One link word per clock_40 cycle
   typedef logic [1:0]  char_is_k_t;       // K flag per byte, bit 0 is the low byte
   typedef logic [1:0]  bxn_lsb_t;         // Bunch-crossing LSBs
   typedef logic [7:0]  k_char_t;          // One 8b10b K character

   localparam int FRAME_LEN    = 4;        // Link words per cluster word
   localparam int TX_BUF_DEPTH = 4;        // Buffer entries, also the initial credit count
   localparam int BUF_PTR_W    = $clog2(TX_BUF_DEPTH);

   typedef logic [$clog2(FRAME_LEN)-1:0] frame_idx_t;   // Word slot inside a frame
   typedef logic [BUF_PTR_W-1:0]         buf_ptr_t;
   typedef logic [BUF_PTR_W:0]           buf_cnt_t;     // Holds 0 up to TX_BUF_DEPTH

   // One buffered entry, 61 bits
   typedef struct packed {
      cluster_data_t data;
      logic          overflow;             // More than 8 clusters found
      logic          bc0;
      logic          resync;
      bxn_lsb_t      bxn_lsbs;
   } gem_word_s;

   // What goes to the transceiver each cycle
   typedef struct packed {
      link_word_t data;
      char_is_k_t isk;
   } tx_link_s;

   // ------------------------------
   // K-codes
   // ------------------------------

   localparam k_char_t K_BC0      = 8'h1C; // K.28.0
   localparam k_char_t K_RESYNC   = 8'h3C; // K.28.1
   localparam k_char_t K_OVERFLOW = 8'hFE; // K.30.7
   localparam k_char_t K_SEP0     = 8'hBC; // K.28.5
   localparam k_char_t K_SEP1     = 8'hF7; // K.23.7
   localparam k_char_t K_SEP2     = 8'hFB; // K.27.7
   localparam k_char_t K_SEP3     = 8'hFD; // K.29.7

   localparam char_is_k_t ISK_SEP  = 2'b01;  // Separator in the low byte
   localparam char_is_k_t ISK_DATA = 2'b00;

   // Comma pattern sent while the link is down
   localparam tx_link_s IDLE_LINK_WORD = '{data: 16'hFFFC, isk: ISK_SEP};

endpackage

/* source/tx_framer.sv */
`timescale 1ns/1ps

module tx_framer import tx_frame_pkg::*; (
   input  logic      clock_40,
   input  logic      rst_n_i,
   input  logic      link_up_i,       // From link control
   input  gem_word_s head_i,          // Show-ahead buffer head
   input  logic      not_empty_i,
   output logic      pop_o,
   output tx_link_s  tx_o             // Registered link word
);

   frame_idx_t    frame_idx;          // Slot of the word sent next
   gem_word_s     frame_word;         // Word that starts a frame, zero when idle
   cluster_data_t held_data;          // Payload for words 1 to 3
   k_char_t       sep;

   // ------------------------------
   // Frame counter
   // ------------------------------

   always_ff @(posedge clock_40 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         frame_idx <= '0;
      end else if (!link_up_i) begin
         frame_idx <= '0;                      // Held at the frame start
      end else if (frame_idx == frame_idx_t'(FRAME_LEN - 1)) begin
         frame_idx <= '0;
      end else begin
         frame_idx <= frame_idx + 1'b1;
      end
   end

   // One word taken per frame, at the frame start only
   assign pop_o      = link_up_i && (frame_idx == '0) && not_empty_i;
   assign frame_word = not_empty_i ? head_i : '0;  // Empty buffer gives an idle frame

   // ------------------------------
   // Separator choice
   // ------------------------------

   // TTC characters win over overflow, else the bunch-crossing cycle code
   always_comb begin
      if (frame_word.bc0) begin
         sep = K_BC0;
      end else if (frame_word.resync) begin
         sep = K_RESYNC;
      end else if (frame_word.overflow) begin
         sep = K_OVERFLOW;
      end else begin
         case (frame_word.bxn_lsbs)
            2'd0:    sep = K_SEP0;
            2'd1:    sep = K_SEP1;
            2'd2:    sep = K_SEP2;
            default: sep = K_SEP3;
         endcase
      end
   end

   // Keep the payload for the rest of the frame
   always_ff @(posedge clock_40) begin
      if (link_up_i && (frame_idx == '0)) begin
         held_data <= frame_word.data;
      end
   end

   // ------------------------------
   // Link word register
   // ------------------------------

   always_ff @(posedge clock_40 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         tx_o <= IDLE_LINK_WORD;
      end else if (!link_up_i) begin
         tx_o <= IDLE_LINK_WORD;               // Commas until the link is up
      end else begin
         case (frame_idx)
            2'd0:    tx_o <= '{data: {frame_word.data[7:0], sep}, isk: ISK_SEP};
            2'd1:    tx_o <= '{data: held_data[23:8],  isk: ISK_DATA};
            2'd2:    tx_o <= '{data: held_data[39:24], isk: ISK_DATA};
            default: tx_o <= '{data: held_data[55:40], isk: ISK_DATA};
         endcase
      end
   end

   // Pops stay a whole frame apart, so each one lands on slot 0
   a_pop_frame_start : assert property (
      @(posedge clock_40) disable iff (!rst_n_i)
      pop_o |=> !pop_o ##1 !pop_o ##1 !pop_o
   ) else $error("Pop outside frame slot 0");

endmodule

/* source/tx_word_buffer.sv */
`timescale 1ns/1ps

module tx_word_buffer import tx_frame_pkg::*; (
   input  logic      clock_40,
   input  logic      rst_n_i,
   input  logic      word_valid_i,    // Sender spends one credit
   input  gem_word_s word_i,
   input  logic      pop_i,           // Framer takes the head entry
   output gem_word_s head_o,          // Show-ahead head entry
   output logic      not_empty_o,
   output logic      credit_o         // One pulse per freed entry
);

   gem_word_s mem [TX_BUF_DEPTH];     // Payload only, no reset
   buf_ptr_t  wr_ptr;
   buf_ptr_t  rd_ptr;
   buf_cnt_t  count;                  // Occupied entries
   logic      full;
   logic      wr_en;
   logic      rd_en;

   // ------------------------------
   // Flags and strobes
   // ------------------------------

   assign full        = (count == buf_cnt_t'(TX_BUF_DEPTH));
   assign not_empty_o = (count != '0);
   assign wr_en       = word_valid_i && !full;  // A write into a full buffer is dropped
   assign rd_en       = pop_i && not_empty_o;
   assign head_o      = mem[rd_ptr];            // Valid from the cycle after the write

   always_ff @(posedge clock_40) begin
      if (wr_en) begin
         mem[wr_ptr] <= word_i;
      end
   end

   // ------------------------------
   // Pointers, count and credits
   // ------------------------------

   always_ff @(posedge clock_40 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two, wraps
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;          // Both or neither
         endcase
         credit_o <= rd_en;                    // High the cycle after the pop edge
      end
   end

   // Sender obeys its credits, so the buffer can never be full at a write
   a_no_write_full : assert property (
      @(posedge clock_40) disable iff (!rst_n_i)
      word_valid_i |-> !full
   ) else $error("Write into a full buffer, sender ignored its credits");

   // Framer only pops what is there
   a_no_pop_empty : assert property (
      @(posedge clock_40) disable iff (!rst_n_i)
      pop_i |-> not_empty_o
   ) else $error("Pop from an empty buffer");

endmodule
